/* Bender.yml */
package:
  name: jpeg_out

sources:
  - include_dirs:
      - .
    files:
      - jpeg_out_pkg.sv
      - bit_packer.sv
      - byte_serializer.sv
      - byte_stuffer.sv
      - jpeg_out_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_jpeg_out.sv

/* bit_packer.sv */
////////////////////////////////////////
// packs code words MSB-first into 32-bit words
// the last code of a frame must carry at least one bit, otherwise the
// frame end is lost
// a partial tail is padded with ones up to the next byte boundary
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "jpeg_out_defs.svh"

module bit_packer (
    input  wire                              clock,
    input  wire                              nreset,
    input  wire jpeg_out_pkg::code_t         code_i,
    input  wire                              code_valid_i,
    output logic                             code_ready_o,
    output jpeg_out_pkg::packed_word_t       word_o,
    output logic                             word_valid_o,
    input  wire                              word_ready_i
);
    import jpeg_out_pkg::*;

    packer_state_e          state_q;
    packer_state_e          state_d;
    logic [`JO_ACC_W-1:0]   acc_q;
    logic [`JO_ACC_W-1:0]   acc_d;
    logic [`JO_ACC_W-1:0]   acc_merged;
    code_len_t              fill_q;
    code_len_t              fill_d;
    code_len_t              fill_sum;
    code_data_t             code_aligned;
    logic                   code_fire;
    logic                   word_free;
    logic                   word_load;
    packed_word_t           word_next;

    // pads the bits after cnt with ones and counts the bytes that hold data
    function automatic packed_word_t pad_word(input code_data_t bits, input code_len_t cnt);
        packed_word_t w;
        code_len_t    rounded;
        rounded  = cnt + code_len_t'(7);
        w.data   = bits | ({`JO_CODE_W{1'b1}} >> cnt);
        w.nbytes = rounded[`JO_LEN_W-1:3];
        w.last   = 1'b1;
        return w;
    endfunction

    // the output slot is free, or it empties on this edge
    assign word_free    = !word_valid_o || word_ready_i;
    assign code_ready_o = (state_q == PK_COLLECT) && word_free;
    assign code_fire    = code_valid_i && code_ready_o;

    // move the low len bits to the top, the unused high bits fall out
    assign code_aligned = code_i.data << (code_len_t'(`JO_CODE_W) - code_i.len);
    assign acc_merged   = acc_q | ({code_aligned, {`JO_CODE_W{1'b0}}} >> fill_q);
    assign fill_sum     = fill_q + code_i.len;

    always_comb begin
        state_d   = state_q;
        acc_d     = acc_q;
        fill_d    = fill_q;
        word_load = 1'b0;
        word_next = '0;
        case (state_q)
            PK_COLLECT: begin
                if (code_fire) begin
                    if (fill_sum >= code_len_t'(`JO_CODE_W)) begin
                        word_load        = 1'b1;
                        word_next.data   = acc_merged[`JO_ACC_W-1 -: `JO_CODE_W];
                        word_next.nbytes = byte_cnt_t'(4);
                        word_next.last   = code_i.last && (fill_sum == code_len_t'(`JO_CODE_W));
                        acc_d            = acc_merged << `JO_CODE_W;
                        fill_d           = fill_sum - code_len_t'(`JO_CODE_W);
                        // leftover bits wait in flush until this word has gone
                        if (code_i.last && (fill_sum != code_len_t'(`JO_CODE_W))) begin
                            state_d = PK_FLUSH;
                        end
                    end else if (code_i.last && (fill_sum != '0)) begin
                        word_load = 1'b1;
                        word_next = pad_word(acc_merged[`JO_ACC_W-1 -: `JO_CODE_W], fill_sum);
                        acc_d     = '0;
                        fill_d    = '0;
                    end else begin
                        acc_d  = acc_merged;
                        fill_d = fill_sum;
                    end
                end
            end
            PK_FLUSH: begin
                if (word_free) begin
                    word_load = 1'b1;
                    word_next = pad_word(acc_q[`JO_ACC_W-1 -: `JO_CODE_W], fill_q);
                    acc_d     = '0;
                    fill_d    = '0;
                    state_d   = PK_COLLECT;
                end
            end
            default: begin
                state_d = PK_COLLECT;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q      <= PK_COLLECT;
            acc_q        <= '0;
            fill_q       <= '0;
            word_valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            acc_q   <= acc_d;
            fill_q  <= fill_d;
            if (word_load) begin
                word_valid_o <= 1'b1;
            end else if (word_ready_i) begin
                word_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (word_load) begin
            word_o <= word_next;
        end
    end

endmodule

`default_nettype wire

/* byte_serializer.sv */
////////////////////////////////////////
// splits packed words into bytes, most significant byte first
// a new word is taken only after the last byte of the current one has gone
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "jpeg_out_defs.svh"

module byte_serializer (
    input  wire                              clock,
    input  wire                              nreset,
    input  wire jpeg_out_pkg::packed_word_t  word_i,
    input  wire                              word_valid_i,
    output logic                             word_ready_o,
    output jpeg_out_pkg::out_byte_t          byte_o,
    output logic                             byte_valid_o,
    input  wire                              byte_ready_i
);
    import jpeg_out_pkg::*;

    code_data_t shift_q;
    byte_cnt_t  remain_q;
    logic       last_q;
    logic       word_fire;
    logic       byte_fire;

    // bytes still to send in the held word
    assign word_ready_o = (remain_q == '0);
    assign word_fire    = word_valid_i && word_ready_o;
    assign byte_valid_o = (remain_q != '0);
    assign byte_fire    = byte_valid_o && byte_ready_i;

    // only the final byte of a flagged word ends the frame
    assign byte_o = '{
        data: shift_q[$bits(code_data_t)-1 -: `JO_BYTE_W],
        last: last_q && (remain_q == `JO_NBYTES_W'(1))
    };

    ////////////////////////////////////////
    // byte count
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (nreset) begin
            remain_q <= '0;
        end else if (word_fire) begin
            remain_q <= word_i.nbytes;
        end else if (byte_fire) begin
            remain_q <= remain_q - `JO_NBYTES_W'(1);
        end
    end

    ////////////////////////////////////////
    // word shift register
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (word_fire) begin
            shift_q <= word_i.data;
            last_q  <= word_i.last;
        end else if (byte_fire) begin
            // next byte moves to the top
            shift_q <= shift_q << `JO_BYTE_W;
        end
    end

endmodule

`default_nettype wire

/* byte_stuffer.sv */
////////////////////////////////////////
// inserts a 0x00 byte after every 0xff byte of the stream
// the output is registered, input is held off while the 0x00 is out
// a last flag on a 0xff moves to the inserted 0x00
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "jpeg_out_defs.svh"

module byte_stuffer (
    input  wire                              clock,
    input  wire                              nreset,
    input  wire jpeg_out_pkg::out_byte_t     byte_i,
    input  wire                              byte_valid_i,
    output logic                             byte_ready_o,
    output jpeg_out_pkg::out_byte_t          byte_o,
    output logic                             byte_valid_o,
    input  wire                              byte_ready_i
);
    import jpeg_out_pkg::*;

    stuffer_state_e state_q;
    out_byte_t      hold_q;
    logic           hold_is_ff;
    logic           in_fire;
    logic           out_fire;
    logic           start_fill;

    assign hold_is_ff = (hold_q.data == `JO_STUFF_BYTE);
    assign out_fire   = byte_valid_o && byte_ready_i;

    // a held 0xff blocks the input, its slot is reused for the 0x00
    assign byte_ready_o = (state_q == ST_PASS) &&
                          (!byte_valid_o || (byte_ready_i && !hold_is_ff));
    assign in_fire      = byte_valid_i && byte_ready_o;
    assign start_fill   = (state_q == ST_PASS) && out_fire && hold_is_ff;

    // the 0xff itself never ends the frame
    assign byte_o = '{
        data: hold_q.data,
        last: hold_q.last && !((state_q == ST_PASS) && hold_is_ff)
    };

    ////////////////////////////////////////
    // FSM and output valid
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q      <= ST_PASS;
            byte_valid_o <= 1'b0;
        end else begin
            case (state_q)
                ST_PASS: begin
                    if (start_fill) begin
                        state_q <= ST_FILL;
                    end else if (in_fire) begin
                        byte_valid_o <= 1'b1;
                    end else if (out_fire) begin
                        byte_valid_o <= 1'b0;
                    end
                end
                ST_FILL: begin
                    if (byte_ready_i) begin
                        state_q      <= ST_PASS;
                        byte_valid_o <= 1'b0;
                    end
                end
                default: begin
                    state_q <= ST_PASS;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // output byte
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (in_fire) begin
            hold_q <= byte_i;
        end else if (start_fill) begin
            // keep last so the inserted byte inherits it
            hold_q.data <= `JO_STUFF_FILL;
        end
    end

endmodule

`default_nettype wire

/* jpeg_out_defs.svh */
////////////////////////////////////////
// widths and constants of the JPEG output back end
// the widths follow the JPEG entropy coded segment and are not meant to change
// a code word is at most 32 bits long
////////////////////////////////////////

`ifndef JPEG_OUT_DEFS_SVH
`define JPEG_OUT_DEFS_SVH

// code word field and its length, lengths run from 0 to 32
`define JO_CODE_W 32
`define JO_LEN_W 6

// packer accumulator holds up to 31 pending bits plus one whole code
`define JO_ACC_W 64

// one byte of the output stream
`define JO_BYTE_W 8

// number of valid bytes in a packed word, 1 to 4
`define JO_NBYTES_W 3

// a 0xff in the entropy coded data is followed by a 0x00
`define JO_STUFF_BYTE 8'hff
`define JO_STUFF_FILL 8'h00

`endif

/* jpeg_out_pkg.sv */
////////////////////////////////////////
// types shared by the JPEG output stages
// code bits are right-aligned, packed words are left-aligned
////////////////////////////////////////

`default_nettype none

`include "jpeg_out_defs.svh"

package jpeg_out_pkg;

    typedef logic [`JO_CODE_W-1:0]   code_data_t;
    typedef logic [`JO_LEN_W-1:0]    code_len_t;
    typedef logic [`JO_BYTE_W-1:0]   byte_t;
    typedef logic [`JO_NBYTES_W-1:0] byte_cnt_t;

    // one variable-length code word from the Huffman coder
    typedef struct packed {
        code_data_t data;
        code_len_t  len;
        logic       last;
    } code_t;

    // packed word, the first bit of the stream sits in the MSB
    typedef struct packed {
        code_data_t data;
        byte_cnt_t  nbytes;
        logic       last;
    } packed_word_t;

    typedef struct packed {
        byte_t data;
        logic  last;
    } out_byte_t;

    typedef enum logic {
        PK_COLLECT,
        PK_FLUSH
    } packer_state_e;

    typedef enum logic {
        ST_PASS,
        ST_FILL
    } stuffer_state_e;

endpackage

`default_nettype wire

/* jpeg_out_top.sv */
////////////////////////////////////////
// JPEG output back end, code words in and stuffed bytes out
// the frame marker stays high until the last byte of a frame has left
// the next frame should start only after the marker has fallen
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module jpeg_out_top (
    input  wire                         clock,
    input  wire                         nreset,
    input  wire jpeg_out_pkg::code_t    code_i,
    input  wire                         code_valid_i,
    output logic                        code_ready_o,
    output jpeg_out_pkg::byte_t         byte_o,
    output logic                        byte_valid_o,
    input  wire                         byte_ready_i,
    output logic                        frame_active_o
);
    import jpeg_out_pkg::*;

    packed_word_t word;
    logic         word_valid;
    logic         word_ready;
    out_byte_t    ser_byte;
    logic         ser_byte_valid;
    logic         ser_byte_ready;
    out_byte_t    out_byte;
    logic         code_fire;
    logic         last_fire;

    bit_packer u_packer (
        .clock        (clock),
        .nreset       (nreset),
        .code_i       (code_i),
        .code_valid_i (code_valid_i),
        .code_ready_o (code_ready_o),
        .word_o       (word),
        .word_valid_o (word_valid),
        .word_ready_i (word_ready)
    );

    byte_serializer u_serializer (
        .clock        (clock),
        .nreset       (nreset),
        .word_i       (word),
        .word_valid_i (word_valid),
        .word_ready_o (word_ready),
        .byte_o       (ser_byte),
        .byte_valid_o (ser_byte_valid),
        .byte_ready_i (ser_byte_ready)
    );

    byte_stuffer u_stuffer (
        .clock        (clock),
        .nreset       (nreset),
        .byte_i       (ser_byte),
        .byte_valid_i (ser_byte_valid),
        .byte_ready_o (ser_byte_ready),
        .byte_o       (out_byte),
        .byte_valid_o (byte_valid_o),
        .byte_ready_i (byte_ready_i)
    );

    assign byte_o    = out_byte.data;
    assign code_fire = code_valid_i && code_ready_o;
    assign last_fire = byte_valid_o && byte_ready_i && out_byte.last;

    // a code of the next frame wins over the end of the current one
    always_ff @(posedge clock) begin
        if (nreset) begin
            frame_active_o <= 1'b0;
        end else if (code_fire) begin
            frame_active_o <= 1'b1;
        end else if (last_fire) begin
            frame_active_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tb_jpeg_out_model.svh */
////////////////////////////////////////
// expected byte stream of one frame of code words
// the caller imports jpeg_out_pkg before this file is included
////////////////////////////////////////

`ifndef TB_JPEG_OUT_MODEL_SVH
`define TB_JPEG_OUT_MODEL_SVH

typedef byte_t byte_list_t[$];

// bits go out MSB-first, the tail is filled with ones to a whole byte
function automatic byte_list_t ref_stream(input code_t codes[$]);
    bit         bits[$];
    byte_list_t bytes;
    byte_t      b;
    int         i;
    int         k;
    for (i = 0; i < codes.size(); i++) begin
        for (k = int'(codes[i].len) - 1; k >= 0; k--) begin
            bits.push_back(codes[i].data[k]);
        end
    end
    while ((bits.size() % 8) != 0) begin
        bits.push_back(1'b1);
    end
    for (i = 0; i < bits.size(); i += 8) begin
        b = 8'h00;
        for (k = 0; k < 8; k++) begin
            b = {b[6:0], bits[i + k]};
        end
        bytes.push_back(b);
        // a 0xff in the data is always followed by a 0x00
        if (b == 8'hff) begin
            bytes.push_back(8'h00);
        end
    end
    return bytes;
endfunction

`endif

/* tb_jpeg_out.sv */
////////////////////////////////////////
// testbench for the JPEG output back end
// each frame starts after all bytes of the one before have come out
// the last code of every frame carries at least one bit
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_jpeg_out;
    import jpeg_out_pkg::*;
    `include "tb_jpeg_out_model.svh"

    logic       clock;
    logic       nreset;
    code_t      code_i;
    logic       code_valid_i;
    logic       code_ready_o;
    byte_t      byte_o;
    logic       byte_valid_o;
    logic       byte_ready_i;
    logic       frame_active_o;
    logic       stall_en;
    logic       setup_done;
    logic       in_frame;
    logic       marker_high_due;
    logic       marker_low_due;
    byte_t      exp_q[$];
    code_t      all_codes[$];
    string      frame_names[$];
    string      test_name;
    int         errors;
    int         bytes_seen;
    int         total_bits;
    int         cycle_limit;

    jpeg_out_top dut0 (
        .clock          (clock),
        .nreset         (nreset),
        .code_i         (code_i),
        .code_valid_i   (code_valid_i),
        .code_ready_o   (code_ready_o),
        .byte_o         (byte_o),
        .byte_valid_o   (byte_valid_o),
        .byte_ready_i   (byte_ready_i),
        .frame_active_o (frame_active_o)
    );

    always #50 clock = ~clock;

    task automatic add_code(input code_data_t data, input int len, input bit last);
        code_t c;
        c.data = data;
        c.len  = code_len_t'(len);
        c.last = last;
        all_codes.push_back(c);
        total_bits += len;
    endtask

    task automatic build_tests;
        int i;
        int f;
        int n;
        // nibbles stay below 0xf, so no 0xff byte can form
        frame_names.push_back("aligned");
        for (i = 0; i < 8; i++) add_code(code_data_t'((i * 5 + 2) % 15), 4, i == 7);
        frame_names.push_back("aligned");
        for (i = 0; i < 24; i++) add_code(code_data_t'((i * 7 + 3) % 15), 4, i == 23);
        frame_names.push_back("stuff");
        add_code(32'hff, 8, 1'b0);
        add_code(32'hfff, 12, 1'b0);
        add_code(32'hf, 4, 1'b0);
        add_code(32'hffffffff, 32, 1'b0);
        add_code(32'h1, 3, 1'b0);
        add_code(32'h3f, 6, 1'b0);
        add_code(32'h7f, 7, 1'b1);
        // the padded tail itself becomes 0xff
        frame_names.push_back("stuff");
        add_code(32'hff, 8, 1'b0);
        add_code(32'h7, 3, 1'b1);
        frame_names.push_back("stuff");
        for (i = 0; i < 4; i++) add_code(32'hff, 8, i == 3);
        frame_names.push_back("flush");
        add_code(32'h0a, 5, 1'b1);
        frame_names.push_back("flush");
        add_code(32'h1234, 13, 1'b0);
        add_code(32'h00, 7, 1'b1);
        frame_names.push_back("flush");
        add_code(32'h0, 20, 1'b0);
        add_code(32'h2aaaaaaa, 30, 1'b0);
        add_code(32'h0, 1, 1'b1);
        frame_names.push_back("flush");
        add_code(32'h0, 31, 1'b0);
        add_code(32'h1, 2, 1'b1);
        for (f = 0; f < 12; f++) begin
            frame_names.push_back("random");
            n = 1 + ($urandom % 40);
            for (i = 0; i < n; i++) add_code($urandom, 1 + ($urandom % 32), i == n - 1);
        end
    endtask

    task automatic check_idle(input string when);
        if (byte_valid_o !== 1'b0 || frame_active_o !== 1'b0 || code_ready_o !== 1'b1) begin
            errors++;
            $display("outputs not idle %s: byte_valid_o=%b frame_active_o=%b code_ready_o=%b",
                     when, byte_valid_o, frame_active_o, code_ready_o);
        end
    endtask

    task automatic run_frame(input string name, input code_t codes[$]);
        byte_list_t expected;
        int         i;
        expected  = ref_stream(codes);
        test_name = name;
        stall_en <= (name == "random");
        foreach (expected[i]) exp_q.push_back(expected[i]);
        for (i = 0; i < codes.size(); i++) begin
            code_i       = codes[i];
            code_valid_i = 1'b1;
            do @(posedge clock); while (code_ready_o !== 1'b1);
            #1;
        end
        code_valid_i = 1'b0;
        do begin
            @(posedge clock);
            #1;
        end while (exp_q.size() != 0);
        // any extra byte shows up in the idle gap
        repeat (4) @(posedge clock);
        #1;
    endtask

    task automatic report_and_finish;
        $display("run complete: %0d errors, %0d bytes compared, %0d bytes never seen",
                 errors, bytes_seen, exp_q.size());
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // output compare and frame marker
    ////////////////////////////////////////

    always @(posedge clock) begin : compare_output
        byte_t want;
        if (nreset == 1'b0) begin
            if (marker_high_due && frame_active_o !== 1'b1) begin
                errors++;
                $display("frame marker is low while test %s still has bytes to send", test_name);
            end
            if (marker_low_due && frame_active_o !== 1'b0) begin
                errors++;
                $display("frame marker still high after the last byte of test %s", test_name);
            end
            marker_low_due = 1'b0;
            if (code_valid_i && code_ready_o) begin
                in_frame = 1'b1;
            end
            if (byte_valid_o && byte_ready_i) begin
                bytes_seen++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected byte %h in test %s, none was expected", byte_o, test_name);
                end else begin
                    want = exp_q.pop_front();
                    if (byte_o !== want) begin
                        errors++;
                        $display("mismatch in test %s: expected %h, actual %h",
                                 test_name, want, byte_o);
                    end
                    if (exp_q.size() == 0) begin
                        in_frame       = 1'b0;
                        marker_low_due = 1'b1;
                    end
                end
            end
            marker_high_due = in_frame;
        end
    end

    always @(posedge clock) begin
        #1;
        if (stall_en) begin
            byte_ready_i = (($urandom % 100) >= 30);
        end else begin
            byte_ready_i = 1'b1;
        end
    end

    initial begin : timeout
        int n;
        wait (setup_done);
        for (n = 0; n < cycle_limit; n++) @(posedge clock);
        errors++;
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        report_and_finish();
    end

    initial begin : stimulus
        code_t frame[$];
        int    i;
        int    idx;
        void'($urandom(32'hde02ab5f));
        clock = 1'b0;
        nreset = 1'b1;
        code_i = '0;
        code_valid_i = 1'b0;
        byte_ready_i = 1'b1;
        stall_en = 1'b0;
        in_frame = 1'b0;
        marker_high_due = 1'b0;
        marker_low_due = 1'b0;
        errors = 0;
        bytes_seen = 0;
        total_bits = 0;
        test_name = "reset";
        build_tests();
        cycle_limit = total_bits / 8 * 4 + 2000;
        setup_done = 1'b1;
        for (i = 0; i < 10; i++) begin
            @(posedge clock);
            if (i > 0) check_idle("during reset");
        end
        #1 nreset = 1'b0;
        repeat (3) begin
            @(posedge clock);
            check_idle("after reset");
        end
        #1;
        idx = 0;
        foreach (all_codes[i]) begin
            frame.push_back(all_codes[i]);
            if (all_codes[i].last) begin
                run_frame(frame_names[idx], frame);
                idx++;
                frame.delete();
            end
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
jpeg_out_pkg.sv
bit_packer.sv
byte_serializer.sv
byte_stuffer.sv
jpeg_out_top.sv
tb_jpeg_out.sv
